//--- all.f
source/accel_pkg.sv
source/cmd_if.sv
source/packet_rx.sv
source/csr_file.sv
source/operand_buffer.sv
source/tile_sequencer.sv
source/mac_array.sv
source/resp_tx.sv
source/accel_top.sv
testbench/tb_clock.sv
testbench/tb_accel_top.sv

//--- Makefile
TOP := tb_accel_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

//--- testbench/tb_accel_top.sv
/*
 * Packet driver, response collector and reference model for the accelerator
 * Concurrent checks, watchdog and final report
 */
`timescale 1ns/1ps

module tb_accel_top;

    localparam int CLK_NS      = 4;
    // Packets sent by all tests together
    localparam int NUM_PACKETS = 121;
    localparam int WATCHDOG_NS = (NUM_PACKETS * 200 + 1000) * CLK_NS;
    localparam int DONE_LIMIT  = 200;
    localparam int RESP_LIMIT  = 200;

    logic       clk;
    logic       rst_n;
    logic [7:0] i_rx_byte;
    logic       i_rx_valid;
    logic       i_tx_ready;
    logic [7:0] o_tx_byte;
    logic       o_tx_valid;
    logic       o_busy;
    logic       o_done;
    logic       o_error;

    integer     seed = 3;
    int         mismatch_count = 0;
    int         assert_count = 0;
    int         other_count = 0;
    int         done_count;
    int         run_kc = 0;
    // Reference copies of the operand buffers
    int         ref_a [16][2];
    int         ref_b [16][2];
    logic [7:0] resp_bytes [5];

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    accel_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rx_byte  (i_rx_byte),
        .i_rx_valid (i_rx_valid),
        .i_tx_ready (i_tx_ready),
        .o_tx_byte  (o_tx_byte),
        .o_tx_valid (o_tx_valid),
        .o_busy     (o_busy),
        .o_done     (o_done),
        .o_error    (o_error)
    );

    // ==============================
    // Concurrent checks
    // ==============================
    assert property (@(posedge clk) disable iff (!rst_n) o_done |=> !o_done)
    else begin
        assert_count++;
        $display("o_done stayed high for more than one cycle at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
                     (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_byte)))
    else begin
        assert_count++;
        $display("Response byte changed under back-pressure at %0t", $time);
    end

    assert property (@(posedge clk) !rst_n |=> (!o_busy && !o_done && !o_tx_valid && !o_error))
    else begin
        assert_count++;
        $display("Control outputs not low after reset at %0t", $time);
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            done_count <= 0;
        end else if (o_done) begin
            done_count <= done_count + 1;
        end
    end

    // ==============================
    // Driver and collector tasks
    // ==============================
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic send_packet(input logic [7:0] cmd, input logic [15:0] addr,
                               input logic [31:0] data, input bit gaps);
        logic [7:0] pkt [7];
        int         gap;
        int         i;
        pkt[0] = cmd;
        pkt[1] = addr[7:0];
        pkt[2] = addr[15:8];
        for (i = 0; i < 4; i++) begin
            pkt[3 + i] = data[8 * i +: 8];
        end
        for (i = 0; i < 7; i++) begin
            gap = gaps ? ($unsigned($random(seed)) % 3) : 0;
            repeat (gap) begin
                @(posedge clk);
                i_rx_valid <= 1'b0;
            end
            @(posedge clk);
            i_rx_valid <= 1'b1;
            i_rx_byte  <= pkt[i];
        end
        @(posedge clk);
        i_rx_valid <= 1'b0;
    endtask

    // Ready toggles at random and bytes are sampled at the falling edge
    task automatic collect_response();
        int n;
        int waited;
        int i;
        n = 0;
        waited = 0;
        for (i = 0; i < 5; i++) begin
            resp_bytes[i] = 8'hxx;
        end
        while (n < 5 && waited < RESP_LIMIT) begin
            @(posedge clk);
            i_tx_ready <= (($random(seed) & 3) != 0);
            @(negedge clk);
            if (o_tx_valid && i_tx_ready) begin
                resp_bytes[n] = o_tx_byte;
                n++;
            end
            waited++;
        end
        @(posedge clk);
        i_tx_ready <= 1'b0;
        if (n < 5) begin
            other_count++;
            $display("Response stopped after %0d of 5 bytes at %0t", n, $time);
        end else begin
            @(negedge clk);
            if (o_tx_valid) begin
                other_count++;
                $display("Response ran past 5 bytes at %0t", $time);
            end
        end
    endtask

    task automatic check_response(input logic [7:0] cmd, input logic [31:0] exp,
                                  input string what);
        collect_response();
        check_value({what, " header"}, {24'h0, resp_bytes[0]}, {24'h0, cmd});
        check_value(what, {resp_bytes[4], resp_bytes[3], resp_bytes[2], resp_bytes[1]}, exp);
    endtask

    task automatic read_and_check(input logic [7:0] cmd, input logic [15:0] addr,
                                  input logic [31:0] exp, input string what);
        send_packet(cmd, addr, 32'h0, 1'b1);
        check_response(cmd, exp, what);
    endtask

    task automatic wait_for_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!o_done && waited < DONE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!o_done) begin
            other_count++;
            $display("o_done did not arrive within %0d cycles at %0t", DONE_LIMIT, $time);
        end
    endtask

    // ==============================
    // Reference model
    // ==============================
    function automatic int expected_sum(input int kc, input int row, input int col);
        int sum;
        int k;
        sum = 0;
        for (k = 0; k < kc; k++) begin
            sum += ref_a[k][row] * ref_b[k][col];
        end
        return sum;
    endfunction

    task automatic start_and_check();
        int idx;
        send_packet({accel_pkg::CMD_START, 4'h0}, 16'h0, 32'h0, 1'b1);
        wait_for_done();
        // Address bit 1 picks the lane of A, bit 0 the lane of B
        for (idx = 0; idx < 4; idx++) begin
            read_and_check({accel_pkg::CMD_BUF_RD_OUT, 4'h0}, 16'(idx),
                           32'(expected_sum(run_kc, idx / 2, idx % 2)),
                           $sformatf("c[%0d][%0d] K=%0d", idx / 2, idx % 2, run_kc));
        end
    endtask

    task automatic run_matmul(input int k_len);
        logic [31:0] rnd;
        int          kc;
        int          k;
        int          l;
        kc = (k_len > 16) ? 16 : k_len;
        for (k = 0; k < kc; k++) begin
            for (l = 0; l < 2; l++) begin
                rnd = $random(seed);
                ref_a[k][l] = int'(byte'(rnd[7:0]));
                ref_b[k][l] = int'(byte'(rnd[15:8]));
            end
            send_packet({accel_pkg::CMD_BUF_WR_A, 4'h0}, 16'(k),
                        {16'h0, 8'(ref_a[k][1]), 8'(ref_a[k][0])}, 1'b1);
            send_packet({accel_pkg::CMD_BUF_WR_B, 4'h0}, 16'(k),
                        {16'h0, 8'(ref_b[k][1]), 8'(ref_b[k][0])}, 1'b1);
        end
        run_kc = kc;
        send_packet({accel_pkg::CMD_CSR_WR, 4'h0}, accel_pkg::CSR_K_LEN, 32'(k_len), 1'b1);
        read_and_check({accel_pkg::CMD_CSR_RD, 4'h0}, accel_pkg::CSR_K_LEN, 32'(k_len),
                       "K_LEN readback");
        start_and_check();
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_csr_access();
        read_and_check({accel_pkg::CMD_STATUS, 4'h0}, 16'h0, 32'h0, "status after reset");
        read_and_check({accel_pkg::CMD_CSR_RD, 4'h0}, accel_pkg::CSR_K_LEN, 32'h0,
                       "K_LEN after reset");
        send_packet({accel_pkg::CMD_CSR_WR, 4'h0}, accel_pkg::CSR_SCRATCH, 32'hA5C3_1E47, 1'b1);
        read_and_check({accel_pkg::CMD_CSR_RD, 4'h0}, accel_pkg::CSR_SCRATCH, 32'hA5C3_1E47,
                       "SCRATCH readback");
        read_and_check({accel_pkg::CMD_CSR_RD, 4'h0}, 16'h0007, 32'h0, "unknown CSR address");
    endtask

    task automatic test_matmul_runs();
        run_matmul(1);
        run_matmul(5);
        run_matmul(16);
        // Clamped to the buffer depth
        run_matmul(20);
        // Same operands again so the sums must not double
        start_and_check();
    endtask

    // Packets without gaps so the status read lands inside the run
    task automatic test_abort();
        int done_before;
        send_packet({accel_pkg::CMD_CSR_WR, 4'h0}, accel_pkg::CSR_K_LEN, 32'd16, 1'b1);
        send_packet({accel_pkg::CMD_START, 4'h0}, 16'h0, 32'h0, 1'b0);
        done_before = done_count;
        send_packet({accel_pkg::CMD_STATUS, 4'h0}, 16'h0, 32'h0, 1'b0);
        send_packet({accel_pkg::CMD_ABORT, 4'h0}, 16'h0, 32'h0, 1'b0);
        // Busy falls one cycle after the abort command, before the run could end
        repeat (2) @(negedge clk);
        check_value("o_busy after abort", 32'(o_busy), 32'h0);
        check_response({accel_pkg::CMD_STATUS, 4'h0}, 32'h1, "status during run");
        repeat (30) @(negedge clk);
        check_value("done pulses after abort", 32'(done_count - done_before), 32'h0);
        read_and_check({accel_pkg::CMD_STATUS, 4'h0}, 16'h0, 32'h0, "status after abort");
    endtask

    task automatic test_illegal_opcode();
        send_packet(8'h90, 16'h0, 32'h0, 1'b1);
        repeat (2) @(negedge clk);
        check_value("o_error after opcode 9", 32'(o_error), 32'h1);
        read_and_check({accel_pkg::CMD_STATUS, 4'h0}, 16'h0, 32'h2, "status error bit");
        check_value("o_error held", 32'(o_error), 32'h1);
    endtask

    initial begin
        i_rx_byte  <= 8'h00;
        i_rx_valid <= 1'b0;
        i_tx_ready <= 1'b0;
        @(posedge rst_n);
        repeat (2) @(posedge clk);
        test_csr_access();
        test_matmul_runs();
        test_abort();
        test_illegal_opcode();
        repeat (4) @(posedge clk);
        $display("Errors: %0d mismatch, %0d assertion, %0d other",
                 mismatch_count, assert_count, other_count);
        if (mismatch_count + assert_count + other_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t before the tests finished", $time);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
/*
 * Testbench clock and synchronous reset source
 */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_NS      = 2;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- source/accel_top.sv
/*
 * Accelerator top level: byte-wide host ports around the command bus
 */
`timescale 1ns/1ps

module accel_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] i_rx_byte,
    input  logic       i_rx_valid,
    input  logic       i_tx_ready,
    output logic [7:0] o_tx_byte,
    output logic       o_tx_valid,
    output logic       o_busy,
    output logic       o_done,
    output logic       o_error
);

    cmd_if cmd_bus ();

    logic                          illegal;
    logic [accel_pkg::K_LEN_W-1:0] k_len;
    accel_pkg::word_t              csr_rdata;
    logic                          rd_en;
    logic [accel_pkg::BUF_AW-1:0]  rd_addr;
    accel_pkg::vec_t               a_vec;
    accel_pkg::vec_t               b_vec;
    logic                          clr;
    logic                          acc_en;
    accel_pkg::acc_t               result;

    // ==============================
    // Command path
    // ==============================
    packet_rx u_packet_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rx_byte  (i_rx_byte),
        .i_rx_valid (i_rx_valid),
        .o_cmd      (cmd_bus),
        .o_illegal  (illegal)
    );

    csr_file u_csr_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_cmd     (cmd_bus),
        .i_illegal (illegal),
        .i_busy    (o_busy),
        .o_k_len   (k_len),
        .o_rdata   (csr_rdata),
        .o_error   (o_error)
    );

    // ==============================
    // Operands and compute
    // ==============================
    operand_buffer #(.WR_OP(accel_pkg::CMD_BUF_WR_A)) u_buf_a (
        .clk       (clk),
        .i_cmd     (cmd_bus),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (a_vec)
    );

    operand_buffer #(.WR_OP(accel_pkg::CMD_BUF_WR_B)) u_buf_b (
        .clk       (clk),
        .i_cmd     (cmd_bus),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (b_vec)
    );

    tile_sequencer u_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_cmd     (cmd_bus),
        .i_k_len   (k_len),
        .o_rd_en   (rd_en),
        .o_rd_addr (rd_addr),
        .o_clr     (clr),
        .o_acc_en  (acc_en),
        .o_busy    (o_busy),
        .o_done    (o_done)
    );

    // Result select from the low address bits of the read command
    mac_array u_mac_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_clr    (clr),
        .i_acc_en (acc_en),
        .i_a      (a_vec),
        .i_b      (b_vec),
        .i_sel    (cmd_bus.addr[1:0]),
        .o_result (result)
    );

    resp_tx u_resp_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_cmd       (cmd_bus),
        .i_csr_rdata (csr_rdata),
        .i_result    (result),
        .i_tx_ready  (i_tx_ready),
        .o_tx_byte   (o_tx_byte),
        .o_tx_valid  (o_tx_valid)
    );

endmodule

//--- source/resp_tx.sv
/*
 * Response serializer: header byte then 4 data bytes, LSB first
 */
`timescale 1ns/1ps

module resp_tx (
    input  logic             clk,
    input  logic             rst_n,
    cmd_if.snk               i_cmd,
    input  accel_pkg::word_t i_csr_rdata,
    input  accel_pkg::acc_t  i_result,
    input  logic             i_tx_ready,
    output logic [7:0]       o_tx_byte,
    output logic             o_tx_valid
);

    logic [2:0]       byte_idx;
    logic [7:0]       hdr_q;
    accel_pkg::word_t word_q;
    logic             is_read;
    logic             load;
    logic             advance;

    assign is_read = (i_cmd.op == accel_pkg::CMD_CSR_RD) ||
                     (i_cmd.op == accel_pkg::CMD_STATUS) ||
                     (i_cmd.op == accel_pkg::CMD_BUF_RD_OUT);

    // Reads arriving mid-response are dropped
    assign load    = i_cmd.valid && is_read && !o_tx_valid;
    assign advance = o_tx_valid && i_tx_ready;

    // ==============================
    // Byte sequencing
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_tx_valid <= 1'b0;
            byte_idx   <= '0;
        end else if (load) begin
            o_tx_valid <= 1'b1;
            byte_idx   <= '0;
        end else if (advance) begin
            // Index 4 is the last data byte
            if (byte_idx == 3'd4) begin
                o_tx_valid <= 1'b0;
            end
            byte_idx <= byte_idx + 3'd1;
        end
    end

    // Low nibble of the command is not carried on the bus, echoed as zero
    always_ff @(posedge clk) begin
        if (load) begin
            hdr_q  <= {i_cmd.op, 4'h0};
            word_q <= (i_cmd.op == accel_pkg::CMD_BUF_RD_OUT) ?
                      accel_pkg::word_t'(i_result) : i_csr_rdata;
        end else if (advance && (byte_idx != '0)) begin
            word_q <= word_q >> 8;
        end
    end

    assign o_tx_byte = (byte_idx == '0) ? hdr_q : word_q[7:0];

endmodule

//--- source/mac_array.sv
/*
 * 2x2 output-stationary signed multiply-accumulate array
 * Combinational select of one accumulator
 */
`timescale 1ns/1ps

module mac_array (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_clr,
    input  logic            i_acc_en,
    input  accel_pkg::vec_t i_a,
    input  accel_pkg::vec_t i_b,
    input  logic [1:0]      i_sel,
    output accel_pkg::acc_t o_result
);

    accel_pkg::acc_t acc_q [accel_pkg::LANES][accel_pkg::LANES];
    accel_pkg::acc_t prod  [accel_pkg::LANES][accel_pkg::LANES];

    // Sign-extend both lanes before the multiply
    always_comb begin
        for (int r = 0; r < accel_pkg::LANES; r++) begin
            for (int c = 0; c < accel_pkg::LANES; c++) begin
                prod[r][c] = accel_pkg::acc_t'(signed'(i_a[r])) *
                             accel_pkg::acc_t'(signed'(i_b[c]));
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < accel_pkg::LANES; r++) begin
            for (int c = 0; c < accel_pkg::LANES; c++) begin
                if (!rst_n || i_clr) begin
                    acc_q[r][c] <= '0;
                end else if (i_acc_en) begin
                    acc_q[r][c] <= acc_q[r][c] + prod[r][c];
                end
            end
        end
    end

    // Row from lane of A, column from lane of B
    assign o_result = acc_q[i_sel[1]][i_sel[0]];

endmodule

//--- source/tile_sequencer.sv
/*
 * Run control: start and abort, k counter, clear and accumulate strobes
 */
`timescale 1ns/1ps

module tile_sequencer (
    input  logic                          clk,
    input  logic                          rst_n,
    cmd_if.snk                            i_cmd,
    input  logic [accel_pkg::K_LEN_W-1:0] i_k_len,
    output logic                          o_rd_en,
    output logic [accel_pkg::BUF_AW-1:0]  o_rd_addr,
    output logic                          o_clr,
    output logic                          o_acc_en,
    output logic                          o_busy,
    output logic                          o_done
);

    typedef enum logic [1:0] {S_IDLE, S_CLR, S_READ, S_DRAIN} state_t;

    state_t                        state;
    logic [accel_pkg::BUF_AW-1:0]  k_q;
    logic [accel_pkg::K_LEN_W-1:0] k_run;
    logic [accel_pkg::K_LEN_W-1:0] k_clamped;
    logic                          start_cmd;
    logic                          abort_cmd;

    assign start_cmd = i_cmd.valid && (i_cmd.op == accel_pkg::CMD_START);
    assign abort_cmd = i_cmd.valid && (i_cmd.op == accel_pkg::CMD_ABORT);

    // Lengths past the buffer depth run the whole buffer
    assign k_clamped = (i_k_len > accel_pkg::K_LEN_W'(accel_pkg::BUF_DEPTH)) ?
                       accel_pkg::K_LEN_W'(accel_pkg::BUF_DEPTH) : i_k_len;

    assign o_busy    = (state != S_IDLE);
    assign o_clr     = (state == S_CLR);
    assign o_rd_en   = (state == S_READ);
    assign o_rd_addr = k_q;

    // Length captured once per run
    always_ff @(posedge clk) begin
        if (start_cmd && (state == S_IDLE)) begin
            k_run <= k_clamped;
        end
    end

    // ==============================
    // Run FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            k_q      <= '0;
            o_acc_en <= 1'b0;
            o_done   <= 1'b0;
        end else begin
            o_done   <= 1'b0;
            // Read data lands one cycle after the read strobe
            o_acc_en <= o_rd_en;
            case (state)
                S_IDLE: begin
                    if (start_cmd) begin
                        state <= S_CLR;
                    end
                end
                S_CLR: begin
                    k_q <= '0;
                    if (k_run == '0) begin
                        state  <= S_IDLE;
                        o_done <= 1'b1;
                    end else begin
                        state <= S_READ;
                    end
                end
                S_READ: begin
                    if (accel_pkg::K_LEN_W'(k_q) == k_run - 1'b1) begin
                        state <= S_DRAIN;
                    end else begin
                        k_q <= k_q + 1'b1;
                    end
                end
                default: begin
                    // Last accumulate happens in this cycle
                    state  <= S_IDLE;
                    o_done <= 1'b1;
                end
            endcase
            // Abort leaves partial sums in place and skips done
            if (abort_cmd && o_busy) begin
                state  <= S_IDLE;
                o_done <= 1'b0;
            end
        end
    end

endmodule

//--- source/operand_buffer.sv
/*
 * Two-lane operand store, written by its own opcode, registered read
 */
`timescale 1ns/1ps

module operand_buffer #(
    parameter accel_pkg::opcode_t WR_OP = accel_pkg::CMD_BUF_WR_A
) (
    input  logic                         clk,
    cmd_if.snk                           i_cmd,
    input  logic                         i_rd_en,
    input  logic [accel_pkg::BUF_AW-1:0] i_rd_addr,
    output accel_pkg::vec_t              o_rd_data
);

    accel_pkg::vec_t mem [accel_pkg::BUF_DEPTH];

    // Lane 0 from data byte 0, lane 1 from data byte 1
    always_ff @(posedge clk) begin
        if (i_cmd.valid && (i_cmd.op == WR_OP)) begin
            mem[i_cmd.addr[accel_pkg::BUF_AW-1:0]] <=
                accel_pkg::vec_t'(i_cmd.data[$bits(accel_pkg::vec_t)-1:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

//--- source/csr_file.sv
/*
 * K_LEN and scratch registers, sticky error flag
 * Combinational read word for CSR read and status
 */
`timescale 1ns/1ps

module csr_file (
    input  logic                          clk,
    input  logic                          rst_n,
    cmd_if.snk                            i_cmd,
    input  logic                          i_illegal,
    input  logic                          i_busy,
    output logic [accel_pkg::K_LEN_W-1:0] o_k_len,
    output accel_pkg::word_t              o_rdata,
    output logic                          o_error
);

    accel_pkg::word_t scratch_q;
    logic             csr_wr;

    assign csr_wr = i_cmd.valid && (i_cmd.op == accel_pkg::CMD_CSR_WR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_k_len   <= '0;
            scratch_q <= '0;
            o_error   <= 1'b0;
        end else begin
            if (csr_wr && (i_cmd.addr == accel_pkg::CSR_K_LEN)) begin
                o_k_len <= i_cmd.data[accel_pkg::K_LEN_W-1:0];
            end
            if (csr_wr && (i_cmd.addr == accel_pkg::CSR_SCRATCH)) begin
                scratch_q <= i_cmd.data;
            end
            // Held until reset
            if (i_illegal) begin
                o_error <= 1'b1;
            end
        end
    end

    // Read word, status takes priority over the address map
    always_comb begin
        o_rdata = '0;
        if (i_cmd.op == accel_pkg::CMD_STATUS) begin
            o_rdata[accel_pkg::STAT_BUSY_BIT] = i_busy;
            o_rdata[accel_pkg::STAT_ERR_BIT]  = o_error;
        end else if (i_cmd.addr == accel_pkg::CSR_K_LEN) begin
            o_rdata = accel_pkg::word_t'(o_k_len);
        end else if (i_cmd.addr == accel_pkg::CSR_SCRATCH) begin
            o_rdata = scratch_q;
        end
    end

endmodule

//--- source/packet_rx.sv
/*
 * Packet receiver: gathers 7 bytes into opcode, address and data
 * Issues one command pulse per packet or flags an illegal opcode
 */
`timescale 1ns/1ps

module packet_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] i_rx_byte,
    input  logic       i_rx_valid,
    cmd_if.src         o_cmd,
    output logic       o_illegal
);

    logic [2:0] byte_cnt;
    logic       last_byte;

    assign last_byte = i_rx_valid && (byte_cnt == 3'(accel_pkg::PKT_BYTES - 1));

    // Byte position and completion pulses
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_cnt    <= '0;
            o_cmd.valid <= 1'b0;
            o_illegal   <= 1'b0;
        end else begin
            o_cmd.valid <= 1'b0;
            o_illegal   <= 1'b0;
            if (last_byte) begin
                byte_cnt <= '0;
                // Codes 8 to F are not defined
                if (o_cmd.op > accel_pkg::CMD_STATUS) begin
                    o_illegal <= 1'b1;
                end else begin
                    o_cmd.valid <= 1'b1;
                end
            end else if (i_rx_valid) begin
                byte_cnt <= byte_cnt + 3'd1;
            end
        end
    end

    // Field capture, address and data arrive LSB first and shift down
    always_ff @(posedge clk) begin
        if (i_rx_valid) begin
            case (byte_cnt)
                3'd0:       o_cmd.op   <= accel_pkg::opcode_t'(i_rx_byte[7:4]);
                3'd1, 3'd2: o_cmd.addr <= {i_rx_byte, o_cmd.addr[15:8]};
                default:    o_cmd.data <= {i_rx_byte, o_cmd.data[31:8]};
            endcase
        end
    end

endmodule

//--- source/cmd_if.sv
/*
 * Decoded command bus, source and sink views
 */
`timescale 1ns/1ps

interface cmd_if;
    logic               valid;
    accel_pkg::opcode_t op;
    logic [15:0]        addr;
    accel_pkg::word_t   data;

    modport src (output valid, output op, output addr, output data);
    modport snk (input valid, input op, input addr, input data);
endinterface

//--- source/accel_pkg.sv
/*
 * Command opcodes, packet and buffer sizes, CSR map
 * Lane, vector, accumulator and data word types
 */
package accel_pkg;

    // ==============================
    // Command opcodes
    // ==============================
    typedef logic [3:0] opcode_t;

    localparam opcode_t CMD_CSR_WR     = 4'h0;
    localparam opcode_t CMD_CSR_RD     = 4'h1;
    localparam opcode_t CMD_BUF_WR_A   = 4'h2;
    localparam opcode_t CMD_BUF_WR_B   = 4'h3;
    localparam opcode_t CMD_BUF_RD_OUT = 4'h4;
    localparam opcode_t CMD_START      = 4'h5;
    localparam opcode_t CMD_ABORT      = 4'h6;
    localparam opcode_t CMD_STATUS     = 4'h7;

    // Command byte, 2 address bytes, 4 data bytes
    localparam int PKT_BYTES = 7;

    // ==============================
    // Buffers, array and CSR map
    // ==============================
    localparam int BUF_DEPTH = 16;
    localparam int BUF_AW    = 4;
    localparam int LANES     = 2;

    // K_LEN register width, values above BUF_DEPTH run as BUF_DEPTH
    localparam int K_LEN_W = 5;

    localparam logic [15:0] CSR_K_LEN   = 16'h0000;
    localparam logic [15:0] CSR_SCRATCH = 16'h0001;

    // Status word bits
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_ERR_BIT  = 1;

    // ==============================
    // Data types
    // ==============================
    typedef logic signed [7:0]  lane_t;
    typedef lane_t [LANES-1:0]  vec_t;
    typedef logic signed [31:0] acc_t;
    typedef logic [31:0]        word_t;

endpackage
